//--- source/uart_ctrl.sv
`timescale 1ns/1ns

module uart_ctrl
    import uart_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    cfg_write_i,
    input  logic [bit_period_w-1:0] cfg_bit_period_i,
    input  data_bits_t              cfg_data_bits_i,
    input  parity_t                 cfg_parity_i,
    input  logic                    fifo_empty_i,
    input  logic                    tx_idle_i,
    output logic                    fifo_pop_o,
    output logic [bit_period_w-1:0] bit_period_o,
    output data_bits_t              data_bits_o,
    output parity_t                 parity_o,
    input  logic                    rx_done_i,
    input  logic [7:0]              rx_byte_i,
    input  logic                    rx_parity_err_i,
    input  logic                    rx_frame_err_i,
    input  logic                    rx_read_i,
    output logic                    rx_valid_o,
    output logic [7:0]              rx_data_o,
    output logic                    rx_parity_err_o,
    output logic                    rx_frame_err_o,
    output logic                    rx_overrun_o
);

    // pop doubles as the transmitter load strobe, idle drops the cycle after
    assign fifo_pop_o = tx_idle_i && !fifo_empty_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            bit_period_o <= reset_bit_period;
            data_bits_o  <= DATA_EIGHT;
            parity_o     <= PARITY_NONE;
        end else if (cfg_write_i) begin
            bit_period_o <= cfg_bit_period_i;
            data_bits_o  <= cfg_data_bits_i;
            parity_o     <= cfg_parity_i;
        end
    end

    // receive holding register
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rx_valid_o      <= 1'b0;
            rx_data_o       <= '0;
            rx_parity_err_o <= 1'b0;
            rx_frame_err_o  <= 1'b0;
        end else if (rx_done_i) begin
            rx_valid_o      <= 1'b1;
            rx_data_o       <= rx_byte_i;
            rx_parity_err_o <= rx_parity_err_i;
            rx_frame_err_o  <= rx_frame_err_i;
        end else if (rx_read_i) begin
            rx_valid_o <= 1'b0;
        end
    end

    // sticky until the host rewrites the configuration
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rx_overrun_o <= 1'b0;
        end else if (cfg_write_i) begin
            rx_overrun_o <= 1'b0;
        end else if (rx_done_i && rx_valid_o && !rx_read_i) begin
            rx_overrun_o <= 1'b1;
        end
    end

endmodule

//--- source/uart_pkg.sv
package uart_pkg;

    // clocks per bit minus one
    localparam int bit_period_w = 24;

    localparam logic [bit_period_w-1:0] reset_bit_period = 24'd15;

    // start, data, parity and stop bits together
    localparam int frame_w = 12;

    localparam int tx_fifo_depth = 4;
    localparam int tx_fifo_ptr_w = $clog2(tx_fifo_depth);

    // receiver sample index, start bit is index zero
    localparam int rx_index_w = 4;

    typedef enum logic {
        DATA_SEVEN,
        DATA_EIGHT
    } data_bits_t;

    typedef enum logic [2:0] {
        PARITY_NONE,
        PARITY_EVEN,
        PARITY_ODD,
        PARITY_MARK,
        PARITY_SPACE
    } parity_t;

endpackage

//--- source/uart_rx.sv
`timescale 1ns/1ns

module uart_rx
    import uart_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic [bit_period_w-1:0] bit_period_i,
    input  data_bits_t              data_bits_i,
    input  parity_t                 parity_i,
    input  logic                    rxd_i,
    output logic                    busy_o,
    output logic                    done_o,
    output logic [7:0]              byte_o,
    output logic                    parity_err_o,
    output logic                    frame_err_o
);

    logic                    rxd_meta_r;
    logic                    rxd_sync_r;
    logic                    rxd_prev_r;
    logic [bit_period_w-1:0] count_r;
    logic [rx_index_w-1:0]   index_r;
    logic [rx_index_w-1:0]   data_last;
    logic [rx_index_w-1:0]   stop_index;
    logic                    parity_on;
    logic [7:0]              shift_r;
    logic                    ones_odd_r;
    logic                    parity_err_next;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rxd_meta_r <= 1'b1;
            rxd_sync_r <= 1'b1;
            rxd_prev_r <= 1'b1;
        end else begin
            rxd_meta_r <= rxd_i;
            rxd_sync_r <= rxd_meta_r;
            rxd_prev_r <= rxd_sync_r;
        end
    end

    assign parity_on  = (parity_i != PARITY_NONE);
    assign data_last  = (data_bits_i == DATA_EIGHT) ? rx_index_w'(8) : rx_index_w'(7);
    assign stop_index = data_last + rx_index_w'(parity_on) + rx_index_w'(1);

    // sampled bit is the parity bit here
    always_comb begin
        case (parity_i)
            PARITY_EVEN:  parity_err_next = ones_odd_r ^ rxd_sync_r;
            PARITY_ODD:   parity_err_next = !(ones_odd_r ^ rxd_sync_r);
            PARITY_MARK:  parity_err_next = !rxd_sync_r;
            PARITY_SPACE: parity_err_next = rxd_sync_r;
            default:      parity_err_next = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_o       <= 1'b0;
            done_o       <= 1'b0;
            count_r      <= '0;
            index_r      <= '0;
            shift_r      <= '0;
            ones_odd_r   <= 1'b0;
            byte_o       <= '0;
            parity_err_o <= 1'b0;
            frame_err_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (!busy_o) begin
                if (rxd_prev_r && !rxd_sync_r) begin
                    // first sample lands half a period into the start bit
                    busy_o       <= 1'b1;
                    count_r      <= bit_period_i >> 1;
                    index_r      <= '0;
                    ones_odd_r   <= 1'b0;
                    parity_err_o <= 1'b0;
                end
            end else if (count_r != '0) begin
                count_r <= count_r - 1'b1;
            end else begin
                count_r <= bit_period_i;
                index_r <= index_r + 1'b1;
                if (index_r == '0) begin
                    // start bit gone by mid-bit, treat as a glitch
                    if (rxd_sync_r) begin
                        busy_o <= 1'b0;
                    end
                end else if (index_r <= data_last) begin
                    shift_r    <= {rxd_sync_r, shift_r[7:1]};
                    ones_odd_r <= ones_odd_r ^ rxd_sync_r;
                end else if (index_r != stop_index) begin
                    parity_err_o <= parity_err_next;
                end else begin
                    busy_o      <= 1'b0;
                    done_o      <= 1'b1;
                    frame_err_o <= !rxd_sync_r;
                    // seven bits end up one place too high
                    byte_o <= (data_bits_i == DATA_EIGHT) ? shift_r : {1'b0, shift_r[7:1]};
                end
            end
        end
    end

endmodule

//--- source/uart_top.sv
`timescale 1ns/1ns

module uart_top
    import uart_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    cfg_write_i,
    input  logic [bit_period_w-1:0] cfg_bit_period_i,
    input  data_bits_t              cfg_data_bits_i,
    input  parity_t                 cfg_parity_i,
    input  logic                    tx_write_i,
    input  logic [7:0]              tx_data_i,
    output logic                    tx_full_o,
    output logic                    txd_o,
    input  logic                    rxd_i,
    output logic                    rx_valid_o,
    output logic [7:0]              rx_data_o,
    output logic                    rx_parity_err_o,
    output logic                    rx_frame_err_o,
    input  logic                    rx_read_i,
    output logic                    rx_overrun_o
);

    logic                    fifo_pop;
    logic [7:0]              fifo_head;
    logic                    fifo_empty;
    logic                    tx_idle;
    logic [bit_period_w-1:0] bit_period;
    data_bits_t              data_bits;
    parity_t                 parity;
    logic                    rx_done;
    logic [7:0]              rx_byte;
    logic                    rx_parity_err;
    logic                    rx_frame_err;

    uart_ctrl uart_ctrl_i (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .cfg_write_i     (cfg_write_i),
        .cfg_bit_period_i(cfg_bit_period_i),
        .cfg_data_bits_i (cfg_data_bits_i),
        .cfg_parity_i    (cfg_parity_i),
        .fifo_empty_i    (fifo_empty),
        .tx_idle_i       (tx_idle),
        .fifo_pop_o      (fifo_pop),
        .bit_period_o    (bit_period),
        .data_bits_o     (data_bits),
        .parity_o        (parity),
        .rx_done_i       (rx_done),
        .rx_byte_i       (rx_byte),
        .rx_parity_err_i (rx_parity_err),
        .rx_frame_err_i  (rx_frame_err),
        .rx_read_i       (rx_read_i),
        .rx_valid_o      (rx_valid_o),
        .rx_data_o       (rx_data_o),
        .rx_parity_err_o (rx_parity_err_o),
        .rx_frame_err_o  (rx_frame_err_o),
        .rx_overrun_o    (rx_overrun_o)
    );

    uart_tx_fifo uart_tx_fifo_i (
        .clk_i  (clk_i),
        .reset_i(reset_i),
        .write_i(tx_write_i),
        .data_i (tx_data_i),
        .pop_i  (fifo_pop),
        .head_o (fifo_head),
        .empty_o(fifo_empty),
        .full_o (tx_full_o)
    );

    // the pop pulse is the load strobe
    uart_tx uart_tx_i (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .bit_period_i(bit_period),
        .data_bits_i (data_bits),
        .parity_i    (parity),
        .load_i      (fifo_pop),
        .data_i      (fifo_head),
        .idle_o      (tx_idle),
        .txd_o       (txd_o)
    );

    uart_rx uart_rx_i (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .bit_period_i(bit_period),
        .data_bits_i (data_bits),
        .parity_i    (parity),
        .rxd_i       (rxd_i),
        .busy_o      (),
        .done_o      (rx_done),
        .byte_o      (rx_byte),
        .parity_err_o(rx_parity_err),
        .frame_err_o (rx_frame_err)
    );

endmodule

//--- source/uart_tx.sv
`timescale 1ns/1ns

module uart_tx
    import uart_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic [bit_period_w-1:0] bit_period_i,
    input  data_bits_t              data_bits_i,
    input  parity_t                 parity_i,
    input  logic                    load_i,
    input  logic [7:0]              data_i,
    output logic                    idle_o,
    output logic                    txd_o
);

    logic [bit_period_w-1:0] count_r;
    logic [frame_w-1:0]      frame_r;
    logic [frame_w-1:0]      frame_next;
    logic                    ones_odd;
    logic                    parity_bit;

    // free running, every zero marks a bit boundary
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            count_r <= '0;
        end else if (count_r == '0) begin
            count_r <= bit_period_i;
        end else begin
            count_r <= count_r - 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            frame_r <= '0;
            txd_o   <= 1'b1;
        end else if (load_i) begin
            frame_r <= frame_next;
        end else if (count_r == '0) begin
            frame_r <= {1'b0, frame_r[frame_w-1:1]};
            txd_o   <= (frame_r == '0) ? 1'b1 : frame_r[0];
        end
    end

    assign idle_o = (frame_r == '0);

    always_comb begin
        ones_odd = ^data_i[6:0];
        if (data_bits_i == DATA_EIGHT) begin
            ones_odd = ones_odd ^ data_i[7];
        end
    end

    // even parity keeps the total count of ones even
    always_comb begin
        case (parity_i)
            PARITY_EVEN:  parity_bit = ones_odd;
            PARITY_ODD:   parity_bit = !ones_odd;
            PARITY_MARK:  parity_bit = 1'b1;
            PARITY_SPACE: parity_bit = 1'b0;
            default:      parity_bit = 1'b0;
        endcase
    end

    // unused top positions stay one and act as stop bits
    always_comb begin
        frame_next      = '1;
        frame_next[0]   = 1'b0;
        frame_next[7:1] = data_i[6:0];
        if (data_bits_i == DATA_EIGHT) begin
            frame_next[8] = data_i[7];
        end
        if (parity_i != PARITY_NONE) begin
            if (data_bits_i == DATA_EIGHT) begin
                frame_next[9] = parity_bit;
            end else begin
                frame_next[8] = parity_bit;
            end
        end
    end

endmodule

//--- source/uart_tx_fifo.sv
`timescale 1ns/1ns

module uart_tx_fifo
    import uart_pkg::*;
(
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       write_i,
    input  logic [7:0] data_i,
    input  logic       pop_i,
    output logic [7:0] head_o,
    output logic       empty_o,
    output logic       full_o
);

    logic [7:0]               mem_r [tx_fifo_depth];
    logic [tx_fifo_ptr_w-1:0] rd_ptr_r;
    logic [tx_fifo_ptr_w-1:0] wr_ptr_r;
    logic [tx_fifo_ptr_w:0]   count_r;
    logic                     push;
    logic                     pop;

    // writes into a full buffer are lost
    assign push = write_i && !full_o;
    assign pop  = pop_i && !empty_o;

    assign empty_o = (count_r == '0);
    assign full_o  = (count_r == (tx_fifo_ptr_w + 1)'(tx_fifo_depth));
    assign head_o  = mem_r[rd_ptr_r];

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_r[wr_ptr_r] <= data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rd_ptr_r <= '0;
            wr_ptr_r <= '0;
            count_r  <= '0;
        end else begin
            if (push) begin
                wr_ptr_r <= wr_ptr_r + 1'b1;
            end
            if (pop) begin
                rd_ptr_r <= rd_ptr_r + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_r <= count_r + 1'b1;
                2'b01:   count_r <= count_r - 1'b1;
                default: count_r <= count_r;
            endcase
        end
    end

endmodule

//--- tb.f
source/uart_pkg.sv
source/uart_ctrl.sv
source/uart_tx_fifo.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_top.sv
verif/uart_asserts.sv
verif/tb_uart.sv

//--- verif/tb_uart.sv
`timescale 1ns/1ns

module tb_uart
    import uart_pkg::*;
();

    localparam int clk_period_ns  = 100;
    localparam int max_bit_clocks = 16;
    // all frames of the run including the two driven by hand
    localparam int planned_frames = 37;
    localparam int watchdog_ns    =
        planned_frames * frame_w * max_bit_clocks * clk_period_ns * 2 + 200000;

    logic                    clk_i;
    logic                    reset_i;
    logic                    cfg_write_i;
    logic [bit_period_w-1:0] cfg_bit_period_i;
    data_bits_t              cfg_data_bits_i;
    parity_t                 cfg_parity_i;
    logic                    tx_write_i;
    logic [7:0]              tx_data_i;
    logic                    tx_full_o;
    logic                    txd_o;
    logic                    rxd_i;
    logic                    rx_valid_o;
    logic [7:0]              rx_data_o;
    logic                    rx_parity_err_o;
    logic                    rx_frame_err_o;
    logic                    rx_read_i;
    logic                    rx_overrun_o;

    logic                    loopback;
    logic                    drive_rxd;
    logic                    auto_read;
    logic                    mon_busy = 1'b0;
    int                      frames_started = 0;
    integer                  seed;
    logic [bit_period_w-1:0] cur_bp;
    data_bits_t              cur_bits;
    logic [frame_w-1:0]      tx_expect [$];
    logic [7:0]              rx_expect [$];

    assign rxd_i = loopback ? txd_o : drive_rxd;

    uart_top uart_top_i (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .cfg_write_i     (cfg_write_i),
        .cfg_bit_period_i(cfg_bit_period_i),
        .cfg_data_bits_i (cfg_data_bits_i),
        .cfg_parity_i    (cfg_parity_i),
        .tx_write_i      (tx_write_i),
        .tx_data_i       (tx_data_i),
        .tx_full_o       (tx_full_o),
        .txd_o           (txd_o),
        .rxd_i           (rxd_i),
        .rx_valid_o      (rx_valid_o),
        .rx_data_o       (rx_data_o),
        .rx_parity_err_o (rx_parity_err_o),
        .rx_frame_err_o  (rx_frame_err_o),
        .rx_read_i       (rx_read_i),
        .rx_overrun_o    (rx_overrun_o)
    );

    // index zero goes out first on the line
    function automatic logic [frame_w-1:0] frame_bits(input logic [7:0] b,
                                                      input data_bits_t bits,
                                                      input parity_t par);
        logic [frame_w-1:0] f;
        int                 n;
        logic               ones;
        f    = '1;
        f[0] = 1'b0;
        n    = (bits == DATA_EIGHT) ? 8 : 7;
        ones = 1'b0;
        for (int i = 0; i < n; i++) begin
            f[i + 1] = b[i];
            ones     = ones ^ b[i];
        end
        case (par)
            PARITY_EVEN:  f[n + 1] = ones;
            PARITY_ODD:   f[n + 1] = !ones;
            PARITY_MARK:  f[n + 1] = 1'b1;
            PARITY_SPACE: f[n + 1] = 1'b0;
            default:      f[n + 1] = 1'b1;
        endcase
        return f;
    endfunction

    function automatic logic [7:0] expected_rx(input logic [7:0] b, input data_bits_t bits);
        return (bits == DATA_EIGHT) ? b : {1'b0, b[6:0]};
    endfunction

    function automatic logic [7:0] next_byte();
        integer r;
        r = $random(seed);
        return r[7:0];
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s is %0h, expected %0h",
                     $time, name, actual, expected);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    task automatic stop_with_error(input string why);
        $display("ERROR at %0t ns: %s", $time, why);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic configure(input logic [bit_period_w-1:0] bp, input data_bits_t bits,
                             input parity_t par);
        cfg_bit_period_i = bp;
        cfg_data_bits_i  = bits;
        cfg_parity_i     = par;
        cfg_write_i      = 1'b1;
        @(negedge clk_i);
        cfg_write_i = 1'b0;
        cur_bp      = bp;
        cur_bits    = bits;
    endtask

    task automatic send_byte(input logic [7:0] b);
        while (tx_full_o) begin
            @(negedge clk_i);
        end
        tx_data_i  = b;
        tx_write_i = 1'b1;
        tx_expect.push_back(frame_bits(b, cur_bits, cfg_parity_i));
        rx_expect.push_back(expected_rx(b, cur_bits));
        @(negedge clk_i);
        tx_write_i = 1'b0;
    endtask

    task automatic read_rx();
        rx_read_i = 1'b1;
        @(negedge clk_i);
        rx_read_i = 1'b0;
    endtask

    task automatic wait_valid();
        while (!rx_valid_o) begin
            @(negedge clk_i);
        end
    endtask

    // waits for both paths to go quiet plus one spare bit period
    task automatic wait_drained();
        while (tx_expect.size() != 0 || rx_expect.size() != 0 || mon_busy || rx_valid_o) begin
            @(negedge clk_i);
        end
        repeat (cur_bp + 1) @(negedge clk_i);
    endtask

    task automatic drive_frame(input logic [frame_w-1:0] f);
        for (int i = 0; i < frame_w; i++) begin
            drive_rxd = f[i];
            repeat (cur_bp + 1) @(negedge clk_i);
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever begin
            #(clk_period_ns / 2) clk_i = ~clk_i;
        end
    end

    initial begin
        #(watchdog_ns);
        $display("Timeout: the tests did not finish within %0d ns", watchdog_ns);
        $display("Regression failed");
        $fatal(1);
    end

    // samples txd_o at mid-bit on negative clock edges
    initial begin : tx_monitor
        logic [frame_w-1:0] got;
        logic [frame_w-1:0] want;
        forever begin
            @(negedge txd_o);
            mon_busy = 1'b1;
            frames_started++;
            if (tx_expect.size() == 0) begin
                stop_with_error("a frame started on txd_o with no byte written");
            end
            want = tx_expect.pop_front();
            repeat ((cur_bp + 1) / 2) @(negedge clk_i);
            for (int i = 0; i < frame_w; i++) begin
                if (i > 0) begin
                    repeat (cur_bp + 1) @(negedge clk_i);
                end
                got[i] = txd_o;
            end
            check_value("txd_o", got, want);
            mon_busy = 1'b0;
        end
    end

    initial begin : rx_checker
        forever begin
            @(negedge clk_i);
            if (auto_read && rx_valid_o) begin
                if (rx_expect.size() == 0) begin
                    stop_with_error("rx_valid_o rose with no byte in flight");
                end
                check_value("rx_data_o", rx_data_o, rx_expect.pop_front());
                check_value("rx_parity_err_o", rx_parity_err_o, 1'b0);
                check_value("rx_frame_err_o", rx_frame_err_o, 1'b0);
                read_rx();
            end
        end
    end

    initial begin : stimulus
        logic [7:0]         b;
        logic [frame_w-1:0] f;
        int                 accepted;
        int                 started_before;
        seed             = 32'h8fdf;
        reset_i          = 1'b1;
        cfg_write_i      = 1'b0;
        cfg_bit_period_i = 24'd15;
        cfg_data_bits_i  = DATA_EIGHT;
        cfg_parity_i     = PARITY_NONE;
        tx_write_i       = 1'b0;
        tx_data_i        = 8'h00;
        rx_read_i        = 1'b0;
        loopback         = 1'b1;
        drive_rxd        = 1'b1;
        auto_read        = 1'b1;
        cur_bp           = 24'd15;
        cur_bits         = DATA_EIGHT;
        repeat (3) @(negedge clk_i);
        reset_i = 1'b0;
        check_value("txd_o", txd_o, 1'b1);
        check_value("rx_valid_o", rx_valid_o, 1'b0);
        check_value("tx_full_o", tx_full_o, 1'b0);
        check_value("rx_overrun_o", rx_overrun_o, 1'b0);
        check_value("rx_parity_err_o", rx_parity_err_o, 1'b0);
        check_value("rx_frame_err_o", rx_frame_err_o, 1'b0);

        // reset configuration has eight bits and no parity
        repeat (8) send_byte(next_byte());
        wait_drained();

        for (int w = 0; w < 2; w++) begin
            for (int p = 0; p < 5; p++) begin
                configure(24'd9, data_bits_t'(w), parity_t'(p));
                repeat (2) send_byte(next_byte());
                wait_drained();
            end
        end

        // one byte leaves for the transmitter at once and four more fill the buffer
        configure(24'd15, DATA_EIGHT, PARITY_ODD);
        accepted       = 0;
        started_before = frames_started;
        while (!tx_full_o) begin
            if (accepted == 8) begin
                stop_with_error("tx_full_o did not rise after eight writes");
            end
            send_byte(next_byte());
            accepted++;
        end
        check_value("bytes accepted before tx_full_o", accepted, 5);
        while (tx_full_o) begin
            @(negedge clk_i);
        end
        check_value("frame started before tx_full_o fell", frames_started > started_before, 1);
        wait_drained();

        // second byte lands on an unread first one
        auto_read = 1'b0;
        send_byte(next_byte());
        send_byte(next_byte());
        wait_valid();
        check_value("rx_data_o", rx_data_o, rx_expect[0]);
        check_value("rx_overrun_o", rx_overrun_o, 1'b0);
        while (!rx_overrun_o) begin
            @(negedge clk_i);
        end
        void'(rx_expect.pop_front());
        check_value("rx_valid_o", rx_valid_o, 1'b1);
        check_value("rx_data_o", rx_data_o, rx_expect.pop_front());
        read_rx();
        check_value("rx_overrun_o", rx_overrun_o, 1'b1);
        wait_drained();
        configure(24'd15, DATA_EIGHT, PARITY_EVEN);
        check_value("rx_overrun_o", rx_overrun_o, 1'b0);

        // line driven by hand with bad parity and then a low stop bit
        loopback = 1'b0;
        b    = next_byte();
        f    = frame_bits(b, DATA_EIGHT, PARITY_EVEN);
        f[9] = !f[9];
        drive_frame(f);
        wait_valid();
        check_value("rx_data_o", rx_data_o, b);
        check_value("rx_parity_err_o", rx_parity_err_o, 1'b1);
        check_value("rx_frame_err_o", rx_frame_err_o, 1'b0);
        read_rx();
        b     = next_byte();
        f     = frame_bits(b, DATA_EIGHT, PARITY_EVEN);
        f[10] = 1'b0;
        drive_frame(f);
        wait_valid();
        check_value("rx_data_o", rx_data_o, b);
        check_value("rx_parity_err_o", rx_parity_err_o, 1'b0);
        check_value("rx_frame_err_o", rx_frame_err_o, 1'b1);
        read_rx();

        repeat (4) @(negedge clk_i);
        $display("Regression passed");
        $finish;
    end

endmodule

//--- verif/uart_asserts.sv
`timescale 1ns/1ns

module uart_asserts (
    input logic clk_i,
    input logic reset_i,
    input logic cfg_write_i,
    input logic txd_i,
    input logic rx_read_i,
    input logic rx_valid_i
);

    // line idles high coming out of reset
    txd_high_after_reset: assert property (@(posedge clk_i) reset_i |=> txd_i)
        else $error("txd_o not high after reset");

    read_single_cycle: assert property (
        @(posedge clk_i) disable iff (reset_i) rx_read_i |=> !rx_read_i
    ) else $error("rx_read_i held longer than one cycle");

    // holding register only empties on a read or a new configuration
    valid_falls_on_read: assert property (
        @(posedge clk_i) disable iff (reset_i)
        $fell(rx_valid_i) |-> ($past(rx_read_i) || $past(cfg_write_i))
    ) else $error("rx_valid_o fell without rx_read_i or a configuration write");

endmodule

bind uart_top uart_asserts uart_asserts_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .cfg_write_i(cfg_write_i),
    .txd_i      (txd_o),
    .rx_read_i  (rx_read_i),
    .rx_valid_i (rx_valid_o)
);
